// File: common/serial_sram_pkg.sv
/* shared types and constants for the serial SRAM loader
   baud_div is fixed at build time, the UART has no runtime rate setting */
`default_nettype none

package serial_sram_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;   // full 64 KiB space, wraps at 0xffff
    typedef logic [7:0]  len_t;    // 0 encodes 256

    // command codes, first byte of every frame
    localparam byte_t cmd_write = 8'h57;   // 'W'
    localparam byte_t cmd_read  = 8'h52;   // 'R'

    // clocks per serial bit, kept small for simulation
    localparam int baud_div   = 16;
    localparam int baud_cnt_w = $clog2(baud_div);

    // loader FSM states
    typedef enum logic [2:0] {
        idle,         // waiting for command byte
        addr_hi,      // address bits 15:8
        addr_lo,      // address bits 7:0
        length,       // byte count
        write_data,   // one SRAM write per received byte
        read_addr,    // address settles on the SRAM
        read_send,    // hand read byte to the transmitter
        read_wait     // transmitter busy with the frame
    } loader_state_t;

endpackage

`default_nettype wire

// File: common/serial_byte_if.sv
/* byte-level handshake between the UART halves and the loader
   rx_stb, rx_err and tx_start are single-cycle pulses, tx_busy is a level */
`timescale 1ns/1ps
`default_nettype none

interface serial_byte_if import serial_sram_pkg::*; ();

    byte_t rx_dat;     // valid while rx_stb is high
    logic  rx_stb;
    logic  rx_err;     // stop bit sampled low
    byte_t tx_dat;
    logic  tx_start;   // only legal while tx_busy is low
    logic  tx_busy;

    modport rx_side (
        output rx_dat,
        output rx_stb,
        output rx_err
    );

    modport tx_side (
        input  tx_dat,
        input  tx_start,
        output tx_busy
    );

    modport host (
        input  rx_dat,
        input  rx_stb,
        input  rx_err,
        output tx_dat,
        output tx_start,
        input  tx_busy
    );

endinterface

`default_nettype wire

// File: uart/uart_rx.sv
/* 8N1 receiver, no parity, baud_div clocks per bit
   a start bit that reads high again at its middle is dropped as a glitch */
`timescale 1ns/1ps
`default_nettype none

module uart_rx import serial_sram_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           rx,
    serial_byte_if.rx_side link
);

    localparam logic [baud_cnt_w-1:0] half_bit = baud_cnt_w'(baud_div / 2 - 1);
    localparam logic [baud_cnt_w-1:0] full_bit = baud_cnt_w'(baud_div - 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t             state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;     // for falling edge detect
    logic [baud_cnt_w-1:0] baud_cnt;
    logic [2:0]            bit_idx;
    byte_t                 shift_reg;
    logic                  stb;
    logic                  err;

    // two-flop synchronizer, idles high like the line
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= rx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            stb      <= 1'b0;
            err      <= 1'b0;
        end else begin
            stb <= 1'b0;
            err <= 1'b0;
            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (baud_cnt == half_bit) begin   // middle of start bit
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? rx_idle : rx_data;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (baud_cnt == full_bit) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (baud_cnt == full_bit) begin
                        stb   <= rx_sync;    // good stop bit
                        err   <= !rx_sync;
                        state <= rx_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == rx_data && baud_cnt == full_bit) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign link.rx_dat = shift_reg;
    assign link.rx_stb = stb;
    assign link.rx_err = err;

    a_stb_err_excl: assert property (@(posedge clk) disable iff (reset)
        !(link.rx_stb && link.rx_err))
        else $error("rx_stb and rx_err high together");

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
/* 8N1 transmitter, LSB first, baud_div clocks per bit
   tx_start is ignored while busy, callers must wait for tx_busy low */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import serial_sram_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    output logic           tx,
    serial_byte_if.tx_side link
);

    localparam logic [baud_cnt_w-1:0] full_bit = baud_cnt_w'(baud_div - 1);

    logic [baud_cnt_w-1:0] baud_cnt;
    logic [3:0]            bit_cnt;     // bits already on the line
    logic [8:0]            shift_reg;   // data bits then stop bit
    logic                  busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            tx       <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (link.tx_start) begin
                busy     <= 1'b1;
                tx       <= 1'b0;            // start bit
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == full_bit) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin       // stop bit done
                busy <= 1'b0;
                tx   <= 1'b1;
            end else begin
                tx      <= shift_reg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && link.tx_start) begin
            shift_reg <= {1'b1, link.tx_dat};
        end else if (busy && baud_cnt == full_bit) begin
            shift_reg <= {1'b1, shift_reg[8:1]};
        end
    end

    assign link.tx_busy = busy;

    // the loader must never start a frame over a running one
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        link.tx_start |-> !link.tx_busy)
        else $error("tx_start while tx_busy");

endmodule

`default_nettype wire

// File: src/sram_loader.sv
/* command parser and SRAM engine, expects a combinational SRAM read
   rx_err in any state drops the command, bytes already written stay written */
`timescale 1ns/1ps
`default_nettype none

module sram_loader import serial_sram_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    serial_byte_if.host link,
    output addr_t       sram_addr,
    output byte_t       sram_wdata,
    output logic        sram_we,
    input  byte_t       sram_rdata
);

    loader_state_t state;
    byte_t         cmd;
    addr_t         addr;
    len_t          remaining;   // counts down, 0 stands for 256
    byte_t         wdata;
    logic          we;
    logic          last;

    assign last = (remaining == 8'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            cmd       <= '0;
            addr      <= '0;
            remaining <= '0;
            we        <= 1'b0;
        end else begin
            we <= 1'b0;
            if (link.rx_err) begin
                state <= idle;                    // abort on framing error
            end else begin
                case (state)
                    idle: begin
                        if (link.rx_stb) begin
                            cmd   <= link.rx_dat;
                            state <= addr_hi;
                        end
                    end
                    addr_hi: begin
                        if (link.rx_stb) begin
                            addr[15:8] <= link.rx_dat;
                            state      <= addr_lo;
                        end
                    end
                    addr_lo: begin
                        if (link.rx_stb) begin
                            addr[7:0] <= link.rx_dat;
                            state     <= length;
                        end
                    end
                    length: begin
                        if (link.rx_stb) begin
                            remaining <= link.rx_dat;
                            case (cmd)
                                cmd_write: state <= write_data;
                                cmd_read:  state <= read_addr;
                                default:   state <= idle;   // unknown, header swallowed
                            endcase
                        end
                    end
                    write_data: begin
                        if (we) begin                     // write cycle ends here
                            addr      <= addr + 16'd1;
                            remaining <= remaining - 8'd1;
                            if (last) begin
                                state <= idle;
                            end
                        end
                        if (link.rx_stb) begin
                            we <= 1'b1;
                        end
                    end
                    read_addr: state <= read_send;
                    read_send: state <= read_wait;
                    read_wait: begin
                        if (!link.tx_busy) begin
                            if (last) begin
                                state <= idle;
                            end else begin
                                addr      <= addr + 16'd1;
                                remaining <= remaining - 8'd1;
                                state     <= read_addr;
                            end
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == write_data && link.rx_stb) begin
            wdata <= link.rx_dat;
        end
    end

    assign sram_addr  = addr;
    assign sram_wdata = wdata;
    assign sram_we    = we;

    // read byte goes straight from the SRAM to the transmitter
    assign link.tx_dat   = sram_rdata;
    assign link.tx_start = (state == read_send);

    a_we_in_write: assert property (@(posedge clk) disable iff (reset)
        sram_we |-> state == write_data)
        else $error("sram_we outside write_data");

endmodule

`default_nettype wire

// File: src/serial_sram_top.sv
/* serial SRAM loader top, 8N1 at baud_div clocks per bit
   SRAM read data must be valid in the same cycle as sram_addr */
`timescale 1ns/1ps
`default_nettype none

module serial_sram_top import serial_sram_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  rx,           // serial in, idles high
    output logic  tx,           // serial out, idles high
    output addr_t sram_addr,
    output byte_t sram_wdata,
    output logic  sram_we,
    input  byte_t sram_rdata
);

    serial_byte_if link ();

    uart_rx uart_rx_i (
        .clk   (clk),
        .reset (reset),
        .rx    (rx),
        .link  (link.rx_side)
    );

    uart_tx uart_tx_i (
        .clk   (clk),
        .reset (reset),
        .tx    (tx),
        .link  (link.tx_side)
    );

    sram_loader sram_loader_i (
        .clk        (clk),
        .reset      (reset),
        .link       (link.host),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_we    (sram_we),
        .sram_rdata (sram_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/tb_serial_sram.sv
/* testbench for serial_sram_top, stimulus and expected bytes come from the golden file
   read bytes are predicted from a reference copy of the SRAM, the file is a cross-check */
`timescale 1ns/1ps
`default_nettype none

module tb_serial_sram import serial_sram_pkg::*; ();

    localparam int    frame_cycles = 10 * baud_div;
    localparam byte_t unknown_cmd  = 8'h3c;
    localparam string golden_path  = "testbench/serial_sram_golden.txt";

    logic  clk;
    logic  reset;
    logic  rx;
    logic  tx;
    addr_t sram_addr;
    byte_t sram_wdata;
    logic  sram_we;
    byte_t sram_rdata;

    byte_t sram_mem [0:65535];   // behavioral SRAM
    byte_t ref_mem  [0:65535];   // expected SRAM contents
    addr_t wr_addr_q [$];
    byte_t wr_data_q [$];
    byte_t tx_q [$];

    string t_name [$];
    string t_op [$];
    addr_t t_addr [$];
    len_t  t_len [$];
    int    t_cnt [$];
    int    t_start [$];          // first byte of the test in t_bytes
    byte_t t_bytes [$];

    int      error_count = 0;
    int      pass_count = 0;
    int      fail_count = 0;
    bit      file_ok;
    bit      wd_armed = 1'b0;
    realtime wd_ns;

    serial_sram_top serial_sram_top_i (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .tx         (tx),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_we    (sram_we),
        .sram_rdata (sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign sram_rdata = sram_mem[sram_addr];   // combinational read

    always @(negedge clk) begin
        if (sram_we === 1'b1) begin
            sram_mem[sram_addr] = sram_wdata;
            wr_addr_q.push_back(sram_addr);
            wr_data_q.push_back(sram_wdata);
        end
    end

    // tx decoder, samples on the falling clock edge
    initial begin
        byte_t b;
        int    k;
        forever begin
            @(negedge tx);
            repeat (baud_div / 2) @(negedge clk);   // middle of start bit
            if (tx === 1'b0) begin
                for (k = 0; k < 8; k++) begin
                    repeat (baud_div) @(negedge clk);
                    b[k] = tx;
                end
                repeat (baud_div) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("%0t: tx frame ended without a stop bit", $time);
                    error_count++;
                end
                tx_q.push_back(b);
            end
        end
    end

    initial begin
        wait (wd_armed);
        #(wd_ns);
        $display("watchdog expired at %0t, the tests did not complete", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %02h, got %02h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_write(input addr_t exp_addr, input byte_t exp_data,
                               input addr_t got_addr, input byte_t got_data);
        if (got_addr !== exp_addr) begin
            $display("** Error at %0t: sram_addr expected %04h, got %04h",
                     $time, exp_addr, got_addr);
            error_count++;
        end
        if (got_data !== exp_data) begin
            $display("** Error at %0t: sram_wdata expected %02h, got %02h",
                     $time, exp_data, got_data);
            error_count++;
        end
    endtask

    // one 8N1 frame on rx, optionally with the stop bit low
    task automatic send_byte(input byte_t b, input bit bad_stop);
        logic [9:0] frame;
        int         i;
        frame = {~bad_stop, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            #1 rx = frame[i];
            repeat (baud_div - 1) @(posedge clk);
        end
        if (bad_stop) begin
            @(posedge clk);
            #1 rx = 1'b1;                   // line back to idle
            repeat (baud_div - 1) @(posedge clk);
        end
    endtask

    task automatic wait_results(input int n_wr, input int n_tx);
        int limit;
        int cycles;
        limit = (n_tx + 2) * frame_cycles * 2;
        cycles = 0;
        while ((wr_addr_q.size() < n_wr || tx_q.size() < n_tx) && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        repeat (frame_cycles) @(posedge clk);   // window for stray writes or bytes
    endtask

    task automatic load_golden(output bit ok);
        int    fd;
        string tok;
        string op;
        int    a_v;
        int    l_v;
        int    n_v;
        int    v;
        int    i;
        fd = $fopen(golden_path, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    void'($fgets(tok, fd));   // rest of a comment line
                end else begin
                    void'($fscanf(fd, "%s %h %h %d", op, a_v, l_v, n_v));
                    t_name.push_back(tok);
                    t_op.push_back(op);
                    t_addr.push_back(addr_t'(a_v));
                    t_len.push_back(len_t'(l_v));
                    t_cnt.push_back(n_v);
                    t_start.push_back(t_bytes.size());
                    for (i = 0; i < n_v; i++) begin
                        void'($fscanf(fd, "%h", v));
                        t_bytes.push_back(byte_t'(v));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t);
        string op;
        int    n;
        int    s;
        int    n_wr;
        int    n_tx;
        int    errors_before;
        int    i;
        addr_t a;
        byte_t cmd;
        byte_t expected;
        op = t_op[t];
        n = t_cnt[t];
        s = t_start[t];
        a = t_addr[t];
        errors_before = error_count;
        n_wr = (op == "W") ? n : (op == "E") ? n - 1 : 0;
        n_tx = (op == "R") ? n : 0;
        cmd = (op == "R") ? cmd_read : (op == "X") ? unknown_cmd : cmd_write;
        wr_addr_q.delete();
        wr_data_q.delete();
        tx_q.delete();
        send_byte(cmd, 1'b0);
        send_byte(a[15:8], 1'b0);
        send_byte(a[7:0], 1'b0);
        send_byte(t_len[t], 1'b0);
        if (op == "W" || op == "E") begin
            for (i = 0; i < n; i++) begin
                send_byte(t_bytes[s + i], op == "E" && i == n - 1);
            end
        end
        wait_results(n_wr, n_tx);
        for (i = 0; i < n_wr; i++) begin
            if (i < wr_addr_q.size()) begin
                check_write(a + addr_t'(i), t_bytes[s + i], wr_addr_q[i], wr_data_q[i]);
            end else begin
                $display("%0t: test %s is missing SRAM write %0d", $time, t_name[t], i);
                error_count++;
            end
            ref_mem[a + addr_t'(i)] = t_bytes[s + i];
        end
        if (wr_addr_q.size() > n_wr) begin
            $display("%0t: test %s made %0d SRAM writes, %0d expected",
                     $time, t_name[t], wr_addr_q.size(), n_wr);
            error_count++;
        end
        for (i = 0; i < n_tx; i++) begin
            expected = ref_mem[a + addr_t'(i)];
            check_byte("golden read byte", expected, t_bytes[s + i]);
            if (i < tx_q.size()) begin
                check_byte("tx", expected, tx_q[i]);
            end else begin
                $display("%0t: test %s is missing tx byte %0d", $time, t_name[t], i);
                error_count++;
            end
        end
        if (tx_q.size() > n_tx) begin
            $display("%0t: test %s sent %0d tx bytes, %0d expected",
                     $time, t_name[t], tx_q.size(), n_tx);
            error_count++;
        end
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %-12s pass", t_name[t]);
        end else begin
            fail_count++;
            $display("test %-12s fail", t_name[t]);
        end
    endtask

    initial begin
        int i;
        int t;
        int total;
        reset = 1'b1;
        rx = 1'b1;
        for (i = 0; i < 65536; i++) begin
            sram_mem[i] = byte_t'(i ^ (i >> 8));   // fill depends on both address bytes
            ref_mem[i] = byte_t'(i ^ (i >> 8));
        end
        load_golden(file_ok);
        if (!file_ok) begin
            $display("golden file %s could not be opened", golden_path);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            total = 0;
            for (t = 0; t < t_name.size(); t++) begin
                total += 4 + t_cnt[t];              // header plus data or read bytes
            end
            wd_ns = total * 10 * baud_div * 10.0 * 2 + 100000.0;
            wd_armed = 1'b1;
            repeat (10) @(posedge clk);
            #1 reset = 1'b0;
            repeat (5) @(posedge clk);
            for (t = 0; t < t_name.size(); t++) begin
                run_test(t);
            end
            $display("tests passed %0d, failed %0d, errors %0d",
                     pass_count, fail_count, error_count);
            if (t_name.size() > 0 && fail_count == 0 && error_count == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/serial_sram_golden.txt
# name op addr len count, then count hex bytes that may wrap onto following lines
# W writes the bytes, R expects them back, X sends an unknown command, E ends on a bad stop bit
w_basic W 1234 04 4 11 22 33 44
r_basic R 1234 04 4 11 22 33 44
w_wrap W FFFE 03 3 A5 5A C3
r_wrap R FFFE 03 3 A5 5A C3
w_page W 0100 00 256
FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0 EF EE ED EC EB EA E9 E8 E7 E6 E5 E4 E3 E2 E1 E0
DF DE DD DC DB DA D9 D8 D7 D6 D5 D4 D3 D2 D1 D0 CF CE CD CC CB CA C9 C8 C7 C6 C5 C4 C3 C2 C1 C0
BF BE BD BC BB BA B9 B8 B7 B6 B5 B4 B3 B2 B1 B0 AF AE AD AC AB AA A9 A8 A7 A6 A5 A4 A3 A2 A1 A0
9F 9E 9D 9C 9B 9A 99 98 97 96 95 94 93 92 91 90 8F 8E 8D 8C 8B 8A 89 88 87 86 85 84 83 82 81 80
7F 7E 7D 7C 7B 7A 79 78 77 76 75 74 73 72 71 70 6F 6E 6D 6C 6B 6A 69 68 67 66 65 64 63 62 61 60
5F 5E 5D 5C 5B 5A 59 58 57 56 55 54 53 52 51 50 4F 4E 4D 4C 4B 4A 49 48 47 46 45 44 43 42 41 40
3F 3E 3D 3C 3B 3A 39 38 37 36 35 34 33 32 31 30 2F 2E 2D 2C 2B 2A 29 28 27 26 25 24 23 22 21 20
1F 1E 1D 1C 1B 1A 19 18 17 16 15 14 13 12 11 10 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00
r_page R 0100 00 256
FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0 EF EE ED EC EB EA E9 E8 E7 E6 E5 E4 E3 E2 E1 E0
DF DE DD DC DB DA D9 D8 D7 D6 D5 D4 D3 D2 D1 D0 CF CE CD CC CB CA C9 C8 C7 C6 C5 C4 C3 C2 C1 C0
BF BE BD BC BB BA B9 B8 B7 B6 B5 B4 B3 B2 B1 B0 AF AE AD AC AB AA A9 A8 A7 A6 A5 A4 A3 A2 A1 A0
9F 9E 9D 9C 9B 9A 99 98 97 96 95 94 93 92 91 90 8F 8E 8D 8C 8B 8A 89 88 87 86 85 84 83 82 81 80
7F 7E 7D 7C 7B 7A 79 78 77 76 75 74 73 72 71 70 6F 6E 6D 6C 6B 6A 69 68 67 66 65 64 63 62 61 60
5F 5E 5D 5C 5B 5A 59 58 57 56 55 54 53 52 51 50 4F 4E 4D 4C 4B 4A 49 48 47 46 45 44 43 42 41 40
3F 3E 3D 3C 3B 3A 39 38 37 36 35 34 33 32 31 30 2F 2E 2D 2C 2B 2A 29 28 27 26 25 24 23 22 21 20
1F 1E 1D 1C 1B 1A 19 18 17 16 15 14 13 12 11 10 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00
x_unknown X 0100 04 0
r_after_x R 0100 02 2 FF FE
e_badstop E 2000 04 2 6D 9E
r_after_e R 2000 02 2 6D 21

// File: serial_sram.f
common/serial_sram_pkg.sv
common/serial_byte_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
src/sram_loader.sv
src/serial_sram_top.sv
testbench/tb_serial_sram.sv

// File: run_sim.sh
#!/bin/sh
# builds tb_serial_sram with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -j 0 \
    --top-module tb_serial_sram \
    -f serial_sram.f \
    -o tb_serial_sram
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_serial_sram > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" "$log"; then
    echo "simulation log has no final result"
    exit 1
fi

exit 0
